/* Makefile */
# Verilator build and run of the V2T calibration loop testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = v2t_cal_tb
FILELIST  = v2t_cal_top.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/v2t_cal_pkg.sv */
/* calibration-side sizes, control and thermometer types,
   and the decision struct passed from the arbiter to the updater */

package v2t_cal_pkg;

    // binary control code of the V2T current sources
    localparam int N_V2T = 4;

    // one thermometer cell per nonzero code
    localparam int N_THM = (1 << N_V2T) - 1;

    // dead-zone delay line
    localparam int N_UNIT_DZ = 8;
    localparam int DZ_SEL_W = $clog2(N_UNIT_DZ);

    // largest reachable control code, loop saturates here
    localparam int CTL_MAX = (1 << N_V2T) - 1;

    typedef logic [N_V2T-1:0] ctl_t;

    typedef logic [N_THM-1:0] thm_t;

    // registered output of the edge arbiter
    typedef struct packed {
        // update strobe, one cycle wide
        logic tick;
        // calibration selected
        logic en_cal;
        // override code, used while calibration is off
        ctl_t ext_ctl;
        // replica crossing later than the reference edge
        logic up;
        // replica early by more than the dead zone
        logic down;
    } arb_dec_t;

endpackage

/* common/v2t_meas_pkg.sv */
/* time-code sizes, reference edge position and the
   registered replica sample handed to the arbiter */

package v2t_meas_pkg;

    // crossing time in fine delay units
    localparam int TCODE_W = 8;

    // half-period edge of clk_v2t
    localparam int REF_EDGE_CODE = 128;

    // each dead-zone tap delays the replica edge by this many units
    localparam int DZ_UNIT_STEPS = 2;

    // one extra bit so a delayed edge past the end of the range does not wrap
    localparam int TSUM_W = TCODE_W + 1;

    typedef logic [TCODE_W-1:0] tcode_t;

    typedef logic [TSUM_W-1:0] tsum_t;

    typedef struct packed {
        logic tick;
        logic en_cal;
        v2t_cal_pkg::ctl_t ext_ctl;
        // number of dead-zone taps in the delayed path
        logic [v2t_cal_pkg::DZ_SEL_W-1:0] dz_sel;
        // replica output crossing for this cycle
        tcode_t tout;
    } meas_smp_t;

endpackage

/* design/cal_tick_gen.sv */
/* stage 1: divide-by-two calibration tick
   and capture of the incoming replica sample */

`timescale 1ns/1ps

module cal_tick_gen (
    input  logic                               clk_v2t,
    input  logic                               rstb,
    input  logic                               en_v2t_cal,
    input  v2t_cal_pkg::ctl_t                  ext_v2t_ctl,
    input  logic [v2t_cal_pkg::DZ_SEL_W-1:0]   dz_v2t,
    input  v2t_meas_pkg::tcode_t               tout_code,
    output v2t_meas_pkg::meas_smp_t            smp
);

    // divided clock, only runs while calibrating
    logic div2_q;

    always_ff @(posedge clk_v2t) begin
        if (!rstb) begin
            div2_q <= 1'b0;
        end else if (en_v2t_cal) begin
            div2_q <= ~div2_q;
        end else begin
            div2_q <= 1'b0;
        end
    end

    // sample register
    // falling edge of div2 in the analog loop maps to tick on the following sample
    always_ff @(posedge clk_v2t) begin
        smp.ext_ctl <= ext_v2t_ctl;
        smp.dz_sel  <= dz_v2t;
        smp.tout    <= tout_code;
        if (!rstb) begin
            smp.tick   <= 1'b0;
            smp.en_cal <= 1'b0;
        end else begin
            smp.tick   <= en_v2t_cal & div2_q;
            smp.en_cal <= en_v2t_cal;
        end
    end

endmodule

/* design/ctl_updater.sv */
/* stage 3: saturating up/down V2T control register
   with the external override while calibration is off */

`timescale 1ns/1ps

module ctl_updater (
    input  logic                    clk_v2t,
    input  logic                    rstb,
    input  v2t_cal_pkg::arb_dec_t   dec,
    output v2t_cal_pkg::ctl_t       v2t_ctl
);

    v2t_cal_pkg::ctl_t ctl_nxt;
    logic              at_max;
    logic              at_min;

    assign at_max = (v2t_ctl == v2t_cal_pkg::ctl_t'(v2t_cal_pkg::CTL_MAX));
    assign at_min = (v2t_ctl == '0);

    always_comb begin
        ctl_nxt = v2t_ctl;
        if (!dec.en_cal) begin
            // override path
            ctl_nxt = dec.ext_ctl;
        end else if (dec.tick) begin
            if (dec.up && !at_max) begin
                // replica slow, more current
                ctl_nxt = v2t_ctl + 1'b1;
            end else if (dec.down && !at_min) begin
                ctl_nxt = v2t_ctl - 1'b1;
            end
        end
    end

    // holds between ticks and inside the dead zone
    always_ff @(posedge clk_v2t) begin
        if (!rstb) begin
            v2t_ctl <= '0;
        end else begin
            v2t_ctl <= ctl_nxt;
        end
    end

endmodule

/* design/replica_edge_arbiter.sv */
/* stage 2: early/late decision of the replica crossing against the
   reference edge, with a tap-selectable dead zone */

`timescale 1ns/1ps

module replica_edge_arbiter (
    input  logic                        clk_v2t,
    input  logic                        rstb,
    input  v2t_meas_pkg::meas_smp_t     smp,
    output v2t_cal_pkg::arb_dec_t       dec
);

    // crossing time after each tap of the dead-zone delay line
    v2t_meas_pkg::tsum_t tap_code [v2t_cal_pkg::N_UNIT_DZ];
    v2t_meas_pkg::tsum_t tout_dz;
    v2t_meas_pkg::tsum_t ref_edge;
    logic                late;
    logic                early_dz;

    always_comb begin
        for (int i = 0; i < v2t_cal_pkg::N_UNIT_DZ; i++) begin
            tap_code[i] = v2t_meas_pkg::tsum_t'(smp.tout)
                        + v2t_meas_pkg::tsum_t'(i * v2t_meas_pkg::DZ_UNIT_STEPS);
        end
    end

    assign tout_dz  = tap_code[smp.dz_sel];
    assign ref_edge = v2t_meas_pkg::tsum_t'(v2t_meas_pkg::REF_EDGE_CODE);

    // first arbiter, undelayed replica edge
    assign late = v2t_meas_pkg::tsum_t'(smp.tout) > ref_edge;

    // second arbiter sees the delayed edge
    // still ahead of the reference means the replica is too fast
    assign early_dz = tout_dz < ref_edge;

    always_ff @(posedge clk_v2t) begin
        dec.ext_ctl <= smp.ext_ctl;
        if (!rstb) begin
            dec.tick   <= 1'b0;
            dec.en_cal <= 1'b0;
            dec.up     <= 1'b0;
            dec.down   <= 1'b0;
        end else begin
            dec.tick   <= smp.tick;
            dec.en_cal <= smp.en_cal;
            dec.up     <= late;
            dec.down   <= early_dz;
        end
    end

endmodule

/* design/thermometer_decoder.sv */
/* stage 4: registered binary-to-thermometer decode
   that enables the V2T current cells */

`timescale 1ns/1ps

module thermometer_decoder (
    input  logic                clk_v2t,
    input  logic                rstb,
    input  v2t_cal_pkg::ctl_t   v2t_ctl,
    output v2t_cal_pkg::thm_t   v2t_ctl_thm
);

    v2t_cal_pkg::thm_t thm_nxt;

    // cell i on for every code above i
    always_comb begin
        for (int i = 0; i < v2t_cal_pkg::N_THM; i++) begin
            thm_nxt[i] = (v2t_ctl > v2t_cal_pkg::ctl_t'(i));
        end
    end

    always_ff @(posedge clk_v2t) begin
        if (!rstb) begin
            v2t_ctl_thm <= '0;
        end else begin
            v2t_ctl_thm <= thm_nxt;
        end
    end

endmodule

/* design/v2t_cal_top.sv */
/* V2T gain calibration loop top: tick generator, edge arbiter,
   control updater and thermometer decoder in a four-stage pipeline */

`timescale 1ns/1ps

module v2t_cal_top (
    input  logic                               clk_v2t,
    input  logic                               rstb,
    input  logic                               en_v2t_cal,
    input  v2t_cal_pkg::ctl_t                  ext_v2t_ctl,
    input  logic [v2t_cal_pkg::DZ_SEL_W-1:0]   dz_v2t,
    input  v2t_meas_pkg::tcode_t               tout_code,
    output v2t_cal_pkg::ctl_t                  v2t_ctl,
    output v2t_cal_pkg::thm_t                  v2t_ctl_thm
);

    v2t_meas_pkg::meas_smp_t smp;
    v2t_cal_pkg::arb_dec_t   dec;

    cal_tick_gen i_tick_gen (
        .clk_v2t     (clk_v2t),
        .rstb        (rstb),
        .en_v2t_cal  (en_v2t_cal),
        .ext_v2t_ctl (ext_v2t_ctl),
        .dz_v2t      (dz_v2t),
        .tout_code   (tout_code),
        .smp         (smp)
    );

    replica_edge_arbiter i_arbiter (
        .clk_v2t (clk_v2t),
        .rstb    (rstb),
        .smp     (smp),
        .dec     (dec)
    );

    // v2t_ctl goes both to the port and to the decoder
    ctl_updater i_updater (
        .clk_v2t (clk_v2t),
        .rstb    (rstb),
        .dec     (dec),
        .v2t_ctl (v2t_ctl)
    );

    thermometer_decoder i_thm_dec (
        .clk_v2t     (clk_v2t),
        .rstb        (rstb),
        .v2t_ctl     (v2t_ctl),
        .v2t_ctl_thm (v2t_ctl_thm)
    );

endmodule

/* dv/v2t_cal_tb.sv */
/* testbench for the V2T calibration loop: clock, reset, segment stimulus
   from the tests file, cycle model of the loop and output compares */

`timescale 1ns/1ps

module v2t_cal_tb;

    localparam int RST_CYCLES     = 16;
    localparam int MAX_LINES      = 256;
    localparam int MAX_SEG_CYCLES = 1000;
    localparam int DRAIN_LIMIT    = 16;
    localparam int TCODE_MAX      = (1 << v2t_meas_pkg::TCODE_W) - 1;

    logic                             clk_v2t;
    logic                             rstb;
    logic                             en_v2t_cal;
    v2t_cal_pkg::ctl_t                ext_v2t_ctl;
    logic [v2t_cal_pkg::DZ_SEL_W-1:0] dz_v2t;
    v2t_meas_pkg::tcode_t             tout_code;
    v2t_cal_pkg::ctl_t                v2t_ctl;
    v2t_cal_pkg::thm_t                v2t_ctl_thm;

    // loop model state
    logic              m_div;
    v2t_cal_pkg::ctl_t m_ctl;

    // expected outputs, delayed to match the pipeline
    v2t_cal_pkg::ctl_t exp_ctl_d1;
    v2t_cal_pkg::ctl_t exp_ctl;
    v2t_cal_pkg::thm_t exp_thm;

    // sample numbers riding along with the expected values
    int   smp_cnt;
    int   idx_d1;
    int   ctl_idx;
    int   thm_idx;
    int   done_idx;
    logic chk_en;

    v2t_cal_top i_dut (
        .clk_v2t     (clk_v2t),
        .rstb        (rstb),
        .en_v2t_cal  (en_v2t_cal),
        .ext_v2t_ctl (ext_v2t_ctl),
        .dz_v2t      (dz_v2t),
        .tout_code   (tout_code),
        .v2t_ctl     (v2t_ctl),
        .v2t_ctl_thm (v2t_ctl_thm)
    );

    always #2 clk_v2t = ~clk_v2t;

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_ctl(input v2t_cal_pkg::ctl_t exp_val, input v2t_cal_pkg::ctl_t act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch at %0t ns: v2t_ctl expected %0d actual %0d",
                     $time, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic check_thm(input v2t_cal_pkg::thm_t exp_val, input v2t_cal_pkg::thm_t act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch at %0t ns: v2t_ctl_thm expected %h actual %h",
                     $time, exp_val, act_val);
            abort_run();
        end
    endtask

    // one cell per code step below the control value
    function automatic v2t_cal_pkg::thm_t thm_of(input v2t_cal_pkg::ctl_t code);
        v2t_cal_pkg::thm_t t;
        for (int i = 0; i < v2t_cal_pkg::N_THM; i++) begin
            t[i] = (i < int'(code));
        end
        return t;
    endfunction

    // decision and update rules applied to one sample
    function automatic v2t_cal_pkg::ctl_t next_ctl(
        input v2t_cal_pkg::ctl_t cur,
        input logic              en,
        input logic              tick,
        input v2t_cal_pkg::ctl_t ext,
        input int                dz,
        input int                tout
    );
        bit late;
        bit early;
        int code;
        late  = tout > v2t_meas_pkg::REF_EDGE_CODE;
        early = !late
              && (tout + dz * v2t_meas_pkg::DZ_UNIT_STEPS < v2t_meas_pkg::REF_EDGE_CODE);
        code  = int'(cur);
        if (!en) begin
            code = int'(ext);
        end else if (tick && late) begin
            code = (code < v2t_cal_pkg::CTL_MAX) ? code + 1 : code;
        end else if (tick && early) begin
            code = (code > 0) ? code - 1 : code;
        end
        return v2t_cal_pkg::ctl_t'(code);
    endfunction

    // model sees the same inputs as the DUT on each rising edge
    always @(posedge clk_v2t) begin
        if (!rstb) begin
            m_div      <= 1'b0;
            m_ctl      <= '0;
            exp_ctl_d1 <= '0;
            exp_ctl    <= '0;
            exp_thm    <= '0;
            smp_cnt    <= 0;
            idx_d1     <= 0;
            ctl_idx    <= 0;
            thm_idx    <= 0;
        end else begin
            m_div      <= en_v2t_cal & ~m_div;
            m_ctl      <= next_ctl(m_ctl, en_v2t_cal, en_v2t_cal & m_div, ext_v2t_ctl,
                                   int'(dz_v2t), int'(tout_code));
            exp_ctl_d1 <= m_ctl;
            exp_ctl    <= exp_ctl_d1;
            exp_thm    <= thm_of(exp_ctl);
            smp_cnt    <= smp_cnt + 1;
            idx_d1     <= smp_cnt;
            ctl_idx    <= idx_d1;
            thm_idx    <= ctl_idx;
        end
    end

    // outputs are settled half a period after the rising edge
    always @(negedge clk_v2t) begin
        if (chk_en) begin
            check_ctl(exp_ctl, v2t_ctl);
            check_thm(exp_thm, v2t_ctl_thm);
            done_idx = thm_idx;
        end
    end

    initial begin
        int    fd;
        string line;
        int    n_fields;
        int    n_lines;
        int    en;
        int    ext;
        int    dz;
        int    base;
        int    jit;
        int    cycles;
        int    tout;
        int    target;
        int    guard;
        clk_v2t     = 1'b0;
        rstb        = 1'b0;
        en_v2t_cal  = 1'b0;
        ext_v2t_ctl = '0;
        dz_v2t      = '0;
        tout_code   = '0;
        chk_en      = 1'b0;
        done_idx    = 0;
        void'($urandom(32'h81108526));

        fd = $fopen("dv/v2t_cal_tests.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open the tests file dv/v2t_cal_tests.txt");
            abort_run();
        end

        // outputs are defined from the first reset edge on
        repeat (2) @(posedge clk_v2t);
        chk_en = 1'b1;
        repeat (RST_CYCLES - 2) @(posedge clk_v2t);
        @(negedge clk_v2t);
        check_ctl('0, v2t_ctl);
        check_thm('0, v2t_ctl_thm);
        rstb = 1'b1;

        n_lines = 0;
        while ($fgets(line, fd) != 0) begin
            n_lines++;
            if (n_lines > MAX_LINES) begin
                $display("error: tests file is longer than %0d lines", MAX_LINES);
                abort_run();
            end
            n_fields = $sscanf(line, "%d %d %d %d %d %d", en, ext, dz, base, jit, cycles);
            if (line.len() == 0 || line.getc(0) == "#" || n_fields <= 0) begin
                continue;
            end
            if (n_fields != 6 || cycles < 1 || cycles > MAX_SEG_CYCLES) begin
                $display("error: malformed segment on line %0d of the tests file", n_lines);
                abort_run();
            end
            for (int c = 0; c < cycles; c++) begin
                tout = base;
                if (jit > 0) begin
                    tout = base + int'($urandom % (2 * jit + 1)) - jit;
                end
                // clamp into the time-code range
                tout = (tout < 0) ? 0 : tout;
                tout = (tout > TCODE_MAX) ? TCODE_MAX : tout;
                @(negedge clk_v2t);
                en_v2t_cal  = en[0];
                ext_v2t_ctl = v2t_cal_pkg::ctl_t'(ext);
                dz_v2t      = dz[v2t_cal_pkg::DZ_SEL_W-1:0];
                tout_code   = v2t_meas_pkg::tcode_t'(tout);
            end
        end
        $fclose(fd);

        // let the last samples reach the thermometer output
        @(negedge clk_v2t);
        target = smp_cnt;
        guard  = 0;
        @(posedge clk_v2t);
        while (done_idx < target) begin
            if (guard >= DRAIN_LIMIT) begin
                $display("error: outputs of the last samples were never compared");
                abort_run();
            end
            @(posedge clk_v2t);
            guard++;
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* dv/v2t_cal_tests.txt */
# columns: en_v2t_cal ext_v2t_ctl dz_v2t tout_base jitter cycles (decimal)
# per-cycle tout_code is tout_base plus a random offset in [-jitter, +jitter]
# override path, control follows the external code
0 5 0 128 0 4
0 12 0 128 0 3
0 15 3 200 0 3
0 0 0 60 0 3
0 9 1 128 4 5
0 3 0 128 0 4
# replica late, climb to full scale and stay there
1 3 0 140 0 40
1 3 5 250 8 10
# mid code, then replica early beyond the dead zone down to zero
0 10 2 128 0 4
1 10 2 100 0 30
1 10 7 0 3 8
# dead zone of 3 taps, boundary at 122
0 8 3 128 0 4
1 8 3 122 0 8
1 8 3 128 0 8
1 8 3 121 0 6
# one tap wider, 121 now holds
1 8 4 121 0 8
1 8 4 119 0 4
# no dead zone, only 128 holds
1 8 0 128 0 6
1 8 0 127 0 4
# widest dead zone, boundary at 114
0 9 7 128 0 4
1 9 7 114 0 8
1 9 7 113 0 4
# jitter around both decision boundaries
1 9 2 126 4 30
1 9 5 123 6 40
1 9 0 128 2 30
# enable toggling restarts the tick phase
1 6 2 135 0 3
0 6 2 135 0 1
1 6 2 135 0 3
0 7 2 100 0 2
1 7 2 100 0 5
0 4 1 130 3 1
1 4 1 130 3 7
0 11 6 117 5 1
1 11 6 117 5 9
0 2 0 128 0 4

/* v2t_cal_top.f */
common/v2t_cal_pkg.sv
common/v2t_meas_pkg.sv
design/cal_tick_gen.sv
design/replica_edge_arbiter.sv
design/ctl_updater.sv
design/thermometer_decoder.sv
design/v2t_cal_top.sv
dv/v2t_cal_tb.sv
